/* verilog/noc_bridge_pkg.sv */
// Shared widths and word layout for the network to AXIS bridge
// Response flits are assumed no wider than request flits
// The AXIS tdata is one header bit above the flit data field
package noc_bridge_pkg;

  ////////////////////
  // Flit widths
  ////////////////////

  localparam int unsigned ReqFlitWidth = 40;
  localparam int unsigned RspFlitWidth = 34;

  // Data field sized for the wider channel
  localparam int unsigned FlitDataWidth =
    (ReqFlitWidth > RspFlitWidth) ? ReqFlitWidth : RspFlitWidth;

  ////////////////////
  // Types
  ////////////////////

  // Channel tag carried in the top bit of every AXIS word
  typedef enum logic {
    request  = 1'b0,
    response = 1'b1
  } channel_hdr_e;

  typedef logic [ReqFlitWidth-1:0] req_flit_t;
  typedef logic [RspFlitWidth-1:0] rsp_flit_t;

  // Header above data, 41 bits with the default widths
  typedef struct packed {
    channel_hdr_e             hdr;
    logic [FlitDataWidth-1:0] data;
  } axis_word_t;

endpackage

/* verilog/flit_rr_arbiter.sv */
// Merges the request and response flit streams into one tagged word stream
// Purely combinational path from inputs to output, only the grant state is registered
// Inputs must hold valid and data until accepted, or the locked grant sees a dropped flit
`timescale 1ns/10ps

module flit_rr_arbiter import noc_bridge_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         req_valid_i,
  input  req_flit_t    req_data_i,
  output logic         req_ready_o,
  input  logic         rsp_valid_i,
  input  rsp_flit_t    rsp_data_i,
  output logic         rsp_ready_o,
  output logic         out_valid_o,
  output axis_word_t   out_word_o,
  input  logic         out_ready_i
);

  // Channel that wins a tie on the next arbitration
  channel_hdr_e prio_q;
  // Grant held across a stalled output
  logic         lock_q;
  channel_hdr_e lock_idx_q;
  channel_hdr_e gnt_idx;

  ////////////////////
  // Grant selection
  ////////////////////

  always_comb begin
    if (lock_q) begin
      gnt_idx = lock_idx_q;
    end else if (req_valid_i && rsp_valid_i) begin
      gnt_idx = prio_q;
    end else if (rsp_valid_i) begin
      gnt_idx = response;
    end else begin
      gnt_idx = request;
    end
  end

  assign out_valid_o = (gnt_idx == response) ? rsp_valid_i : req_valid_i;

  // Loser sees ready low, both high while idle
  assign req_ready_o = out_ready_i & (~out_valid_o | (gnt_idx == request));
  assign rsp_ready_o = out_ready_i & (~out_valid_o | (gnt_idx == response));

  // Tag with the grant, zero-extend the narrower flit
  always_comb begin
    out_word_o.hdr  = gnt_idx;
    out_word_o.data = '0;
    if (gnt_idx == response) begin
      out_word_o.data[RspFlitWidth-1:0] = rsp_data_i;
    end else begin
      out_word_o.data[ReqFlitWidth-1:0] = req_data_i;
    end
  end

  ////////////////////
  // Grant state
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q     <= request;
      lock_q     <= 1'b0;
      lock_idx_q <= request;
    end else if (out_valid_o && out_ready_i) begin
      // Pass priority to the other channel
      prio_q <= (gnt_idx == request) ? response : request;
      lock_q <= 1'b0;
    end else if (out_valid_o) begin
      // Stalled, hold this grant
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

endmodule

/* verilog/stream_fifo.sv */
// Valid/ready FIFO for any packed payload type
// Depth of at least 1, output data comes straight from the storage registers
// No push while full, so ready_o never depends on ready_i
`timescale 1ns/10ps

module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);
  localparam logic [CntWidth-1:0] FullCnt = CntWidth'(Depth);

  payload_t            mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  // Status from the fill count only
  assign ready_o = (count_q != FullCnt);
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* verilog/axis_flit_demux.sv */
// Steers incoming AXIS words to the request or response channel by header
// Combinational only, the word must stay stable while in_valid_i is high
// Data above each flit width is dropped
`timescale 1ns/10ps

module axis_flit_demux import noc_bridge_pkg::*; (
  input  logic       in_valid_i,
  input  axis_word_t in_word_i,
  output logic       in_ready_o,
  output logic       req_valid_o,
  output req_flit_t  req_data_o,
  input  logic       req_ready_i,
  output logic       rsp_valid_o,
  output rsp_flit_t  rsp_data_o,
  input  logic       rsp_ready_i
);

  logic sel_rsp;

  // Header decode, the only place it is looked at
  assign sel_rsp = (in_word_i.hdr == response);

  ////////////////////
  // Handshake
  ////////////////////

  // Unselected channel keeps valid low
  assign req_valid_o = in_valid_i & ~sel_rsp;
  assign rsp_valid_o = in_valid_i & sel_rsp;

  // Only the target channel can stall the beat
  assign in_ready_o = sel_rsp ? rsp_ready_i : req_ready_i;

  ////////////////////
  // Payload
  ////////////////////

  // Truncate to each flit width
  assign req_data_o = in_word_i.data[ReqFlitWidth-1:0];
  assign rsp_data_o = in_word_i.data[RspFlitWidth-1:0];

endmodule

/* verilog/noc_axis_bridge.sv */
// Bridge between the request/response flit channels and one AXIS link
// Single clock domain, no tkeep/tlast or other sideband
// At least one cycle of latency in each direction through the FIFOs
`timescale 1ns/10ps

module noc_axis_bridge import noc_bridge_pkg::*; #(
  parameter int unsigned OutFifoDepth    = 2,
  parameter int unsigned EgressFifoDepth = 2
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Flits from the network
  input  logic       req_valid_i,
  input  req_flit_t  req_data_i,
  output logic       req_ready_o,
  input  logic       rsp_valid_i,
  input  rsp_flit_t  rsp_data_i,
  output logic       rsp_ready_o,
  // AXIS out
  output logic       axis_out_tvalid_o,
  output axis_word_t axis_out_tdata_o,
  input  logic       axis_out_tready_i,
  // AXIS in
  input  logic       axis_in_tvalid_i,
  input  axis_word_t axis_in_tdata_i,
  output logic       axis_in_tready_o,
  // Flits to the network
  output logic       req_valid_o,
  output req_flit_t  req_data_o,
  input  logic       req_ready_i,
  output logic       rsp_valid_o,
  output rsp_flit_t  rsp_data_o,
  input  logic       rsp_ready_i
);

  // Arbiter to output FIFO
  logic       arb_valid;
  axis_word_t arb_word;
  logic       arb_ready;

  // Demux to egress FIFOs
  logic      dmx_req_valid;
  req_flit_t dmx_req_data;
  logic      dmx_req_ready;
  logic      dmx_rsp_valid;
  rsp_flit_t dmx_rsp_data;
  logic      dmx_rsp_ready;

  ////////////////////
  // Network to AXIS
  ////////////////////

  flit_rr_arbiter flit_rr_arbiter_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_data_i  (req_data_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_i (rsp_valid_i),
    .rsp_data_i  (rsp_data_i),
    .rsp_ready_o (rsp_ready_o),
    .out_valid_o (arb_valid),
    .out_word_o  (arb_word),
    .out_ready_i (arb_ready)
  );

  // Registers the merged word before it leaves
  stream_fifo #(.payload_t(axis_word_t), .Depth(OutFifoDepth)) out_fifo_inst (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .valid_i (arb_valid), .data_i (arb_word), .ready_o (arb_ready),
    .valid_o (axis_out_tvalid_o), .data_o (axis_out_tdata_o), .ready_i (axis_out_tready_i)
  );

  ////////////////////
  // AXIS to network
  ////////////////////

  axis_flit_demux axis_flit_demux_inst (
    .in_valid_i (axis_in_tvalid_i), .in_word_i (axis_in_tdata_i),
    .in_ready_o (axis_in_tready_o),
    .req_valid_o (dmx_req_valid), .req_data_o (dmx_req_data), .req_ready_i (dmx_req_ready),
    .rsp_valid_o (dmx_rsp_valid), .rsp_data_o (dmx_rsp_data), .rsp_ready_i (dmx_rsp_ready)
  );

  // One egress FIFO per channel
  stream_fifo #(.payload_t(req_flit_t), .Depth(EgressFifoDepth)) req_fifo_inst (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .valid_i (dmx_req_valid), .data_i (dmx_req_data), .ready_o (dmx_req_ready),
    .valid_o (req_valid_o), .data_o (req_data_o), .ready_i (req_ready_i)
  );

  stream_fifo #(.payload_t(rsp_flit_t), .Depth(EgressFifoDepth)) rsp_fifo_inst (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .valid_i (dmx_rsp_valid), .data_i (dmx_rsp_data), .ready_o (dmx_rsp_ready),
    .valid_o (rsp_valid_o), .data_o (rsp_data_o), .ready_i (rsp_ready_i)
  );

endmodule

/* verif/noc_axis_bridge_props.sv */
// Stream protocol checks bound onto the bridge top level
// Hold checks are disabled while reset is asserted
// fail_count lets the testbench see failures at the end of the run
`timescale 1ns/10ps

module noc_axis_bridge_props import noc_bridge_pkg::*; (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       out_valid_i,
  input axis_word_t out_data_i,
  input logic       out_ready_i,
  input logic       req_valid_i,
  input req_flit_t  req_data_i,
  input logic       req_ready_i,
  input logic       rsp_valid_i,
  input rsp_flit_t  rsp_data_i,
  input logic       rsp_ready_i
);

  int unsigned fail_count = 0;

  ////////////////////
  // Hold under back-pressure
  ////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else begin
      $error("AXIS out word dropped or changed while stalled");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_data_i))
    else begin
      $error("Request flit dropped or changed while stalled");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_data_i))
    else begin
      $error("Response flit dropped or changed while stalled");
      fail_count++;
    end

  ////////////////////
  // Reset
  ////////////////////

  // Idle while held and on the first cycle out of reset
  assert property (@(posedge clk_i)
    !rst_n_i || $rose(rst_n_i) |-> !out_valid_i && !req_valid_i && !rsp_valid_i)
    else begin
      $error("Output valid high during or right after reset");
      fail_count++;
    end

endmodule

bind noc_axis_bridge noc_axis_bridge_props noc_axis_bridge_props_inst (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .out_valid_i (axis_out_tvalid_o),
  .out_data_i  (axis_out_tdata_o),
  .out_ready_i (axis_out_tready_i),
  .req_valid_i (req_valid_o),
  .req_data_i  (req_data_o),
  .req_ready_i (req_ready_i),
  .rsp_valid_i (rsp_valid_o),
  .rsp_data_i  (rsp_data_o),
  .rsp_ready_i (rsp_ready_i)
);

/* verif/tb_noc_axis_bridge.sv */
// Testbench for the network to AXIS bridge
// Reference queues fill on input transfers, immediate assertions check each output transfer
// Random data, gaps and ready back-pressure all come from one fixed seed
`timescale 1ns/10ps

module tb_noc_axis_bridge import noc_bridge_pkg::*; ();

  localparam int WaitLimit = 2000;
  localparam int NumWords  = 48;

  logic clk_i, rst_n_i;
  logic req_valid_i, req_ready_o, rsp_valid_i, rsp_ready_o;
  req_flit_t req_data_i;
  rsp_flit_t rsp_data_i;
  logic axis_out_tvalid_o, axis_out_tready_i, axis_in_tvalid_i, axis_in_tready_o;
  axis_word_t axis_out_tdata_o, axis_in_tdata_i;
  logic req_valid_o, req_ready_i, rsp_valid_o, rsp_ready_i;
  req_flit_t req_data_o;
  rsp_flit_t rsp_data_o;

  integer seed = 32'hbc2e_1ccf;
  int errors = 0, words_out = 0, tests_run = 0, tests_failed = 0, alt_count = 0;
  logic random_ready = 1'b0;
  logic check_alternate = 1'b0;

  // Expected words, oldest first
  axis_word_t exp_axis[$];
  req_flit_t  exp_req[$];
  rsp_flit_t  exp_rsp[$];

  noc_axis_bridge noc_axis_bridge_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [63:0] random_bits();
    return {$random(seed), $random(seed)};
  endfunction

  // Sink readies, about one low cycle in four when randomized
  always @(posedge clk_i) begin
    axis_out_tready_i <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
    req_ready_i       <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
    rsp_ready_i       <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
  end

  ////////////////////
  // Scoreboard
  ////////////////////

  // An x expectation means nothing was pending
  always @(posedge clk_i) begin : scoreboard
    axis_word_t   exp_w;
    req_flit_t    exp_r;
    rsp_flit_t    exp_s;
    channel_hdr_e exp_hdr;
    if (!rst_n_i) begin
      alt_count = 0;
    end else begin
      // Network in, header plus zero-extended flit
      if (req_valid_i && req_ready_o) exp_axis.push_back({request, FlitDataWidth'(req_data_i)});
      if (rsp_valid_i && rsp_ready_o) exp_axis.push_back({response, FlitDataWidth'(rsp_data_i)});
      // AXIS in, routed by header and truncated
      if (axis_in_tvalid_i && axis_in_tready_o) begin
        if (axis_in_tdata_i.hdr == response) begin
          exp_rsp.push_back(axis_in_tdata_i.data[RspFlitWidth-1:0]);
        end else begin
          exp_req.push_back(axis_in_tdata_i.data[ReqFlitWidth-1:0]);
        end
      end
      if (axis_out_tvalid_o && axis_out_tready_i) begin
        words_out++;
        exp_w = (exp_axis.size() != 0) ? exp_axis[0] : 'x;
        assert (axis_out_tdata_o === exp_w) else begin
          $display("** Error at %0t: axis_out_tdata_o expected %h, got %h",
            $time, exp_w, axis_out_tdata_o);
          errors++;
        end
        if (exp_axis.size() != 0) exp_axis.delete(0);
        // Round robin from reset, request first
        if (check_alternate) begin
          exp_hdr = (alt_count % 2 == 0) ? request : response;
          assert (axis_out_tdata_o.hdr == exp_hdr) else begin
            $display("** Error at %0t: axis_out_tdata_o.hdr expected %0d, got %0d",
              $time, exp_hdr, axis_out_tdata_o.hdr);
            errors++;
          end
          alt_count++;
        end
      end
      if (req_valid_o && req_ready_i) begin
        words_out++;
        exp_r = (exp_req.size() != 0) ? exp_req[0] : 'x;
        assert (req_data_o === exp_r) else begin
          $display("** Error at %0t: req_data_o expected %h, got %h", $time, exp_r, req_data_o);
          errors++;
        end
        if (exp_req.size() != 0) exp_req.delete(0);
      end
      if (rsp_valid_o && rsp_ready_i) begin
        words_out++;
        exp_s = (exp_rsp.size() != 0) ? exp_rsp[0] : 'x;
        assert (rsp_data_o === exp_s) else begin
          $display("** Error at %0t: rsp_data_o expected %h, got %h", $time, exp_s, rsp_data_o);
          errors++;
        end
        if (exp_rsp.size() != 0) exp_rsp.delete(0);
      end
    end
  end

  ////////////////////
  // Drivers
  ////////////////////

  // Channel 0 request, 1 response, 2 AXIS in
  task automatic set_valid(input int chan, input logic v);
    case (chan)
      0:       req_valid_i <= v;
      1:       rsp_valid_i <= v;
      default: axis_in_tvalid_i <= v;
    endcase
  endtask

  function automatic logic ready_for(input int chan);
    case (chan)
      0:       return req_ready_o;
      1:       return rsp_ready_o;
      default: return axis_in_tready_o;
    endcase
  endfunction

  task automatic send_words(input int chan, input int count, input bit gaps);
    int n, waited;
    logic [63:0] r;
    for (n = 0; n < count; n++) begin
      if (gaps) begin
        set_valid(chan, 1'b0);
        repeat ($unsigned($random(seed)) % 3) @(posedge clk_i);
      end
      r = random_bits();
      set_valid(chan, 1'b1);
      case (chan)
        0:       req_data_i <= r[ReqFlitWidth-1:0];
        1:       rsp_data_i <= r[RspFlitWidth-1:0];
        default: axis_in_tdata_i <= r[$bits(axis_word_t)-1:0];
      endcase
      waited = 0;
      @(posedge clk_i);
      while (!ready_for(chan) && waited < WaitLimit) begin
        @(posedge clk_i);
        waited++;
      end
      if (!ready_for(chan)) begin
        $display("Timeout: input channel %0d not accepted within %0d cycles at %0t",
          chan, WaitLimit, $time);
        errors++;
        n = count;
      end
    end
    set_valid(chan, 1'b0);
  endtask

  // Sampled on the falling edge, away from the scoreboard updates
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_axis.size() + exp_req.size() + exp_rsp.size() != 0 && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_axis.size() + exp_req.size() + exp_rsp.size() != 0) begin
      $display("Timeout: %0d words never came out at %0t",
        exp_axis.size() + exp_req.size() + exp_rsp.size(), $time);
      errors++;
    end
    @(posedge clk_i);
  endtask

  // 16 cycles low, then 4 more, checking idle state on every edge
  task automatic run_reset();
    int i;
    rst_n_i <= 1'b0;
    for (i = 0; i < 20; i++) begin
      @(posedge clk_i);
      assert ({axis_out_tvalid_o, req_valid_o, rsp_valid_o} == 3'b000) else begin
        $display("** Error at %0t: %s expected 000, got %b", $time,
          "{axis_out_tvalid_o, req_valid_o, rsp_valid_o}",
          {axis_out_tvalid_o, req_valid_o, rsp_valid_o});
        errors++;
      end
      assert ({req_ready_o, rsp_ready_o, axis_in_tready_o} == 3'b111) else begin
        $display("** Error at %0t: %s expected 111, got %b", $time,
          "{req_ready_o, rsp_ready_o, axis_in_tready_o}",
          {req_ready_o, rsp_ready_o, axis_in_tready_o});
        errors++;
      end
      if (i == 15) rst_n_i <= 1'b1;
    end
  endtask

  task automatic report(input string name, input int err0, input int words0);
    tests_run++;
    if (errors == err0) begin
      $display("Test %0d %s: pass, %0d words out", tests_run, name, words_out - words0);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL, %0d errors", tests_run, name, errors - err0);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : main
    int err0, words0;
    req_valid_i <= 1'b0;
    req_data_i <= '0;
    rsp_valid_i <= 1'b0;
    rsp_data_i <= '0;
    axis_in_tvalid_i <= 1'b0;
    axis_in_tdata_i <= '0;
    axis_out_tready_i <= 1'b1;
    req_ready_i <= 1'b1;
    rsp_ready_i <= 1'b1;
    err0 = errors;
    words0 = words_out;
    run_reset();
    report("reset state", err0, words0);
    err0 = errors;
    words0 = words_out;
    send_words(0, NumWords, 1'b1);
    wait_drain();
    report("request flits alone", err0, words0);
    err0 = errors;
    words0 = words_out;
    send_words(1, NumWords, 1'b1);
    wait_drain();
    report("response flits alone", err0, words0);
    // Fresh reset so the priority pointer starts at request
    err0 = errors;
    words0 = words_out;
    run_reset();
    check_alternate <= 1'b1;
    fork
      send_words(0, NumWords, 1'b0);
      send_words(1, NumWords, 1'b0);
    join
    wait_drain();
    check_alternate <= 1'b0;
    report("round robin alternation", err0, words0);
    err0 = errors;
    words0 = words_out;
    send_words(2, 2 * NumWords, 1'b1);
    wait_drain();
    report("AXIS in routing", err0, words0);
    err0 = errors;
    words0 = words_out;
    random_ready <= 1'b1;
    fork
      send_words(0, NumWords, 1'b1);
      send_words(1, NumWords, 1'b1);
      send_words(2, 2 * NumWords, 1'b1);
    join
    wait_drain();
    random_ready <= 1'b0;
    report("random back-pressure", err0, words0);
    errors += noc_axis_bridge_inst.noc_axis_bridge_props_inst.fail_count;
    $display("Tests run: %0d, failed: %0d, errors: %0d, protocol failures: %0d",
      tests_run, tests_failed, errors, noc_axis_bridge_inst.noc_axis_bridge_props_inst.fail_count);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* noc_axis_bridge.f */
verilog/noc_bridge_pkg.sv
verilog/flit_rr_arbiter.sv
verilog/stream_fifo.sv
verilog/axis_flit_demux.sv
verilog/noc_axis_bridge.sv
verif/noc_axis_bridge_props.sv
verif/tb_noc_axis_bridge.sv

/* Bender.yml */
package:
  name: noc_axis_bridge

sources:
  # Package first, then leaf modules, then the top level
  - verilog/noc_bridge_pkg.sv
  - verilog/flit_rr_arbiter.sv
  - verilog/stream_fifo.sv
  - verilog/axis_flit_demux.sv
  - verilog/noc_axis_bridge.sv

  # Bound protocol checks and the testbench
  - target: test
    files:
      - verif/noc_axis_bridge_props.sv
      - verif/tb_noc_axis_bridge.sv
